// File: list.f
rv_exe_pkg.sv
credit_fifo.sv
exe_alu.sv
csr_regs.sv
exe_stage.sv
exe_top.sv
exe_top_properties.sv
tb_exe_top.sv

// File: tb_exe_top.sv
/* testbench for the execute stage top
   table-driven requests with credit models on both sides */
`timescale 1ns/1ns
`default_nettype none

module tb_exe_top;

  localparam logic [1:0]  chk_none = 2'd0;
  localparam logic [1:0]  chk_tbl  = 2'd1;
  localparam logic [1:0]  chk_csr  = 2'd2;
  localparam logic [63:0] neg1     = '1;
  localparam logic [63:0] min_int  = 64'h8000_0000_0000_0000;
  localparam logic [63:0] w_neg    = 64'hFFFF_FFFF_8000_0000;
  localparam int          hold_cycles = 20;

  typedef struct {
    rv_exe_pkg::exe_req_t req;
    rv_exe_pkg::exe_rsp_t exp;
    logic [1:0]           chk;
  } row_t;

  logic                 i_clk;
  logic                 i_rst_n;
  logic                 i_req_valid;
  rv_exe_pkg::exe_req_t i_req;
  logic                 o_req_credit;
  logic                 i_rsp_credit;
  logic                 o_rsp_valid;
  rv_exe_pkg::exe_rsp_t o_rsp;

  row_t        rows[$];
  row_t        exp_q[$];
  logic [63:0] csr_shadow [3];
  int          seed = 83;
  int          cycle, idx, sent, rsp_seen, req_credits, pending, limit;

  exe_top u_exe_top (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_req_valid  (i_req_valid),
    .i_req        (i_req),
    .o_req_credit (o_req_credit),
    .i_rsp_credit (i_rsp_credit),
    .o_rsp_valid  (o_rsp_valid),
    .o_rsp        (o_rsp)
  );

  initial begin
    i_clk = 1'b0;
    forever #20 i_clk = ~i_clk;
  end

  task automatic fail_now(input string why);
    $display("*** FAILED ***");
    $fatal(1, "run stopped: %s", why);
  endtask

  task automatic add_row(input rv_exe_pkg::exe_op_e op, input logic [63:0] a,
                         input logic [63:0] b, input logic [63:0] c,
                         input logic [63:0] wdata, input logic jmp,
                         input logic [63:0] jaddr, input logic skip, input logic [1:0] chk);
    row_t r;
    r.req = '{op: op, op1: a, op2: b, op3: c};
    r.exp = '{rd_wdata: wdata, pc_jmp: jmp, pc_jmpaddr: jaddr, skip_cmt: skip};
    r.chk = chk;
    rows.push_back(r);
  endtask

  task automatic add_alu_row(input rv_exe_pkg::exe_op_e op, input logic [63:0] a,
                             input logic [63:0] b, input logic [63:0] want);
    add_row(op, a, b, 64'd0, want, 1'b0, 64'd0, 1'b0, chk_tbl);
  endtask

  task automatic add_branch_row(input rv_exe_pkg::exe_op_e op, input logic [63:0] a,
                                input logic [63:0] b, input logic taken);
    add_row(op, a, b, 64'h0000_0000_8000_0100, 64'd0, taken, 64'h0000_0000_8000_0100,
            1'b0, chk_tbl);
  endtask

  // mcycle reads are not predictable so only skip_cmt is checked there
  task automatic add_csr_row(input rv_exe_pkg::exe_op_e op, input logic [11:0] addr,
                             input logic [63:0] val);
    if (addr == rv_exe_pkg::CSR_MCYCLE)
      add_row(op, val, {52'd0, addr}, 64'd0, 64'd0, 1'b0, 64'd0, 1'b1, chk_none);
    else
      add_row(op, val, {52'd0, addr}, 64'd0, 64'd0, 1'b0, 64'd0, 1'b0, chk_csr);
  endtask

  task automatic build_table();
    add_csr_row(rv_exe_pkg::OP_CSRRS, rv_exe_pkg::CSR_MSCRATCH, 64'd0);
    add_alu_row(rv_exe_pkg::OP_ADD, 64'd5, 64'd7, 64'd12);
    add_alu_row(rv_exe_pkg::OP_SUB, 64'd5, 64'd7, 64'hFFFF_FFFF_FFFF_FFFE);
    add_alu_row(rv_exe_pkg::OP_ADDIW, 64'h7FFF_FFFF, 64'd1, w_neg);
    add_alu_row(rv_exe_pkg::OP_SUBW, 64'd0, 64'd1, neg1);
    add_alu_row(rv_exe_pkg::OP_SLLW, 64'd1, 64'd31, w_neg);
    // shift amount 36 uses only its low 5 bits
    add_alu_row(rv_exe_pkg::OP_SRLW, w_neg, 64'd36, 64'h0800_0000);
    add_alu_row(rv_exe_pkg::OP_SRAW, w_neg, 64'd4, 64'hFFFF_FFFF_F800_0000);
    add_alu_row(rv_exe_pkg::OP_AND, 64'hF0F0, 64'hFF00, 64'hF000);
    add_alu_row(rv_exe_pkg::OP_ORI, 64'hF0, 64'h0F, 64'hFF);
    add_alu_row(rv_exe_pkg::OP_XOR, 64'hFF, 64'h0F, 64'hF0);
    add_alu_row(rv_exe_pkg::OP_SLL, 64'd1, 64'd63, min_int);
    add_alu_row(rv_exe_pkg::OP_SRL, min_int, 64'd63, 64'd1);
    add_alu_row(rv_exe_pkg::OP_SRA, min_int, 64'd63, neg1);
    add_alu_row(rv_exe_pkg::OP_SLT, neg1, 64'd1, 64'd1);
    add_alu_row(rv_exe_pkg::OP_SLTU, neg1, 64'd1, 64'd0);
    add_alu_row(rv_exe_pkg::OP_LUI, 64'h1234_5000, 64'd0, 64'h1234_5000);
    add_alu_row(rv_exe_pkg::OP_AUIPC, 64'h1000, 64'h200, 64'h1200);
    add_branch_row(rv_exe_pkg::OP_BEQ, 64'd3, 64'd3, 1'b1);
    add_branch_row(rv_exe_pkg::OP_BEQ, 64'd3, 64'd4, 1'b0);
    add_branch_row(rv_exe_pkg::OP_BNE, 64'd3, 64'd4, 1'b1);
    add_branch_row(rv_exe_pkg::OP_BNE, 64'd3, 64'd3, 1'b0);
    add_branch_row(rv_exe_pkg::OP_BLT, neg1, 64'd1, 1'b1);
    add_branch_row(rv_exe_pkg::OP_BLT, 64'd1, neg1, 1'b0);
    add_branch_row(rv_exe_pkg::OP_BGE, 64'd1, neg1, 1'b1);
    add_branch_row(rv_exe_pkg::OP_BGE, neg1, 64'd1, 1'b0);
    add_branch_row(rv_exe_pkg::OP_BLTU, 64'd1, neg1, 1'b1);
    add_branch_row(rv_exe_pkg::OP_BLTU, neg1, 64'd1, 1'b0);
    add_branch_row(rv_exe_pkg::OP_BGEU, neg1, 64'd1, 1'b1);
    add_branch_row(rv_exe_pkg::OP_BGEU, 64'd1, neg1, 1'b0);
    add_row(rv_exe_pkg::OP_JAL, 64'h1000, 64'd4, 64'h2000, 64'h1004, 1'b1, 64'h2000,
            1'b0, chk_tbl);
    add_row(rv_exe_pkg::OP_JALR, 64'h3001, 64'h10, 64'h1008, 64'h1008, 1'b1, 64'h3010,
            1'b0, chk_tbl);
    add_csr_row(rv_exe_pkg::OP_CSRRW, rv_exe_pkg::CSR_MSCRATCH, 64'hA5A5);
    add_csr_row(rv_exe_pkg::OP_CSRRS, rv_exe_pkg::CSR_MSCRATCH, 64'h0F00);
    add_csr_row(rv_exe_pkg::OP_CSRRC, rv_exe_pkg::CSR_MSCRATCH, 64'h00A5);
    add_csr_row(rv_exe_pkg::OP_CSRRS, rv_exe_pkg::CSR_MSCRATCH, 64'd0);
    add_csr_row(rv_exe_pkg::OP_CSRRWI, rv_exe_pkg::CSR_MTVEC, 64'd5);
    add_csr_row(rv_exe_pkg::OP_CSRRSI, rv_exe_pkg::CSR_MTVEC, 64'd0);
    add_csr_row(rv_exe_pkg::OP_CSRRS, rv_exe_pkg::CSR_MCYCLE, 64'd0);
  endtask

  // csr model keeps the new value and returns the old one
  task automatic predict_csr(inout row_t r);
    logic [63:0] old_val;
    logic [63:0] new_val;
    int          slot;
    slot = (r.req.op2[11:0] == rv_exe_pkg::CSR_MSCRATCH) ? 0 :
           (r.req.op2[11:0] == rv_exe_pkg::CSR_MTVEC) ? 1 : 2;
    old_val = csr_shadow[slot];
    case (r.req.op)
      rv_exe_pkg::OP_CSRRW, rv_exe_pkg::OP_CSRRWI: new_val = r.req.op1;
      rv_exe_pkg::OP_CSRRS, rv_exe_pkg::OP_CSRRSI: new_val = old_val | r.req.op1;
      default:                                     new_val = old_val & ~r.req.op1;
    endcase
    csr_shadow[slot] = new_val;
    r.exp.rd_wdata = old_val;
  endtask

  task automatic compare_field(input string name, input logic [63:0] got,
                               input logic [63:0] want, input string op_name);
    assert (got === want) else begin
      $display("** Error %s: got %h expected %h (%s)", name, got, want, op_name);
      fail_now("response field mismatch");
    end
  endtask

  task automatic check_rsp();
    row_t r;
    assert (exp_q.size() != 0) else fail_now("response arrived with no request outstanding");
    r = exp_q.pop_front();
    if (r.chk != chk_none)
      compare_field("rd_wdata", o_rsp.rd_wdata, r.exp.rd_wdata, r.req.op.name());
    compare_field("pc_jmp", {63'd0, o_rsp.pc_jmp}, {63'd0, r.exp.pc_jmp}, r.req.op.name());
    compare_field("pc_jmpaddr", o_rsp.pc_jmpaddr, r.exp.pc_jmpaddr, r.req.op.name());
    compare_field("skip_cmt", {63'd0, o_rsp.skip_cmt}, {63'd0, r.exp.skip_cmt},
                  r.req.op.name());
  endtask

  initial begin
    row_t r;
    i_rst_n      = 1'b0;
    i_req_valid  = 1'b0;
    i_req        = '0;
    i_rsp_credit = 1'b0;
    csr_shadow   = '{default: 64'd0};
    build_table();
    limit       = rows.size() * 20 + 200;
    req_credits = rv_exe_pkg::REQ_DEPTH;
    repeat (10) @(posedge i_clk);
    #5 i_rst_n = 1'b1;
    // quiet outputs before any request
    repeat (3) begin
      @(posedge i_clk);
      #5;
      assert (!o_rsp_valid && !o_req_credit) else fail_now("output active before any request");
    end
    while (!(idx == rows.size() && exp_q.size() == 0)) begin
      @(posedge i_clk);
      #5;
      cycle++;
      assert (cycle < limit) else fail_now("timeout waiting for responses");
      if (o_req_credit) req_credits++;
      if (o_rsp_valid) begin
        check_rsp();
        rsp_seen++;
        pending++;
      end
      // downstream holds its credits at first and then returns them at random
      if (cycle <= hold_cycles) begin
        i_rsp_credit = 1'b0;
        assert (rsp_seen <= rv_exe_pkg::RSP_CREDITS)
          else fail_now("more responses than downstream credits while credits were held");
      end else if (pending > 0 && ($random(seed) & 1)) begin
        i_rsp_credit = 1'b1;
        pending--;
      end else begin
        i_rsp_credit = 1'b0;
      end
      if (cycle == hold_cycles) begin
        assert (rsp_seen == rv_exe_pkg::RSP_CREDITS && req_credits == 0 &&
                sent == rv_exe_pkg::REQ_DEPTH + rv_exe_pkg::RSP_CREDITS)
          else fail_now("upstream did not stall with a full queue and no downstream credit");
      end
      if (idx < rows.size() && req_credits > 0) begin
        r = rows[idx];
        if (r.chk == chk_csr) predict_csr(r);
        exp_q.push_back(r);
        i_req_valid = 1'b1;
        i_req       = r.req;
        idx++;
        sent++;
        req_credits--;
      end else begin
        i_req_valid = 1'b0;
        i_req       = '0;
      end
    end
    i_rsp_credit = 1'b0;
    // no response may follow the last expected one
    repeat (4) begin
      @(posedge i_clk);
      #5;
      if (o_rsp_valid) rsp_seen++;
    end
    if (rsp_seen == rows.size()) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      fail_now("response count differs from request count");
    end
  end

endmodule

`default_nettype wire

// File: exe_top_properties.sv
/* protocol checks for the execute stage top
   credit and valid rules, bound into exe_top */
`timescale 1ns/1ns
`default_nettype none

module exe_top_properties (
  input wire                              i_clk,
  input wire                              i_rst_n,
  input wire                              i_req_valid,
  input wire                              i_req_credit,
  input wire                              i_rsp_valid,
  input wire                              i_rsp_credit,
  input wire [rv_exe_pkg::RSP_CNT_W-1:0]  i_rsp_cnt
);

  logic [rv_exe_pkg::RSP_CNT_W:0] rsp_held;
  logic [rv_exe_pkg::REQ_CNT_W:0] req_held;

  // port-level view of downstream credits and queued requests
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      rsp_held <= (rv_exe_pkg::RSP_CNT_W + 1)'(rv_exe_pkg::RSP_CREDITS);
      req_held <= '0;
    end else begin
      rsp_held <= rsp_held + i_rsp_credit - i_rsp_valid;
      req_held <= req_held + i_req_valid - i_req_credit;
    end
  end

  // a credit returned in the same cycle may pay for the send
  property p_valid_needs_credit;
    @(posedge i_clk) disable iff (!i_rst_n)
      i_rsp_valid |-> ((rsp_held + i_rsp_credit) != '0);
  endproperty

  property p_credit_bounded;
    @(posedge i_clk) disable iff (!i_rst_n)
      i_rsp_cnt <= rv_exe_pkg::RSP_CNT_W'(rv_exe_pkg::RSP_CREDITS);
  endproperty

  // credit pulse needs a request pushed and not yet credited
  property p_credit_needs_entry;
    @(posedge i_clk) disable iff (!i_rst_n)
      i_req_credit |-> (req_held != '0);
  endproperty

  a_valid_needs_credit: assert property (p_valid_needs_credit)
    else $error("response valid sent without a downstream credit");
  a_credit_bounded: assert property (p_credit_bounded)
    else $error("downstream credit count above its reset value");
  a_credit_needs_entry: assert property (p_credit_needs_entry)
    else $error("request credit returned from an empty queue");

endmodule

bind exe_top exe_top_properties u_exe_top_properties (
  .i_clk        (i_clk),
  .i_rst_n      (i_rst_n),
  .i_req_valid  (i_req_valid),
  .i_req_credit (o_req_credit),
  .i_rsp_valid  (o_rsp_valid),
  .i_rsp_credit (i_rsp_credit),
  .i_rsp_cnt    (u_exe_stage.rsp_cnt)
);

`default_nettype wire

// File: exe_top.sv
/* execute stage top
   credit request queue feeding the execute stage */
`timescale 1ns/1ns
`default_nettype none

module exe_top (
  input  wire                  i_clk,
  input  wire                  i_rst_n,
  input  wire                  i_req_valid,
  input  rv_exe_pkg::exe_req_t i_req,
  output logic                 o_req_credit,
  input  wire                  i_rsp_credit,
  output logic                 o_rsp_valid,
  output rv_exe_pkg::exe_rsp_t o_rsp
);

  rv_exe_pkg::exe_req_t head;
  logic                 nonempty;
  logic                 pop;

  credit_fifo u_credit_fifo (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_push     (i_req_valid),
    .i_data     (i_req),
    .i_pop      (pop),
    .o_head     (head),
    .o_nonempty (nonempty),
    .o_credit   (o_req_credit)
  );

  exe_stage u_exe_stage (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_head       (head),
    .i_nonempty   (nonempty),
    .i_rsp_credit (i_rsp_credit),
    .o_pop        (pop),
    .o_rsp_valid  (o_rsp_valid),
    .o_rsp        (o_rsp)
  );

endmodule

`default_nettype wire

// File: exe_stage.sv
/* execute stage controller
   pops requests against downstream credits and registers the result */
`timescale 1ns/1ns
`default_nettype none

module exe_stage (
  input  wire                  i_clk,
  input  wire                  i_rst_n,
  input  rv_exe_pkg::exe_req_t i_head,
  input  wire                  i_nonempty,
  input  wire                  i_rsp_credit,
  output logic                 o_pop,
  output logic                 o_rsp_valid,
  output rv_exe_pkg::exe_rsp_t o_rsp
);

  logic [rv_exe_pkg::RSP_CNT_W-1:0] rsp_cnt;
  rv_exe_pkg::exe_rsp_t             alu_rsp;
  logic [11:0]                      csr_addr;
  logic                             csr_ren;
  logic                             csr_wen;
  logic [rv_exe_pkg::XLEN-1:0]      csr_wdata;
  logic [rv_exe_pkg::XLEN-1:0]      csr_rdata;

  // credit is spent at the pop, the response leaves one cycle later
  assign o_pop = i_nonempty && (rsp_cnt != '0);

  exe_alu u_exe_alu (
    .i_ena       (o_pop),
    .i_req       (i_head),
    .i_csr_rdata (csr_rdata),
    .o_csr_addr  (csr_addr),
    .o_csr_ren   (csr_ren),
    .o_csr_wen   (csr_wen),
    .o_csr_wdata (csr_wdata),
    .o_rsp       (alu_rsp)
  );

  csr_regs u_csr_regs (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_addr  (csr_addr),
    .i_ren   (csr_ren),
    .i_wen   (csr_wen),
    .i_wdata (csr_wdata),
    .o_rdata (csr_rdata)
  );

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      rsp_cnt     <= rv_exe_pkg::RSP_CNT_W'(rv_exe_pkg::RSP_CREDITS);
      o_rsp_valid <= 1'b0;
    end else begin
      rsp_cnt     <= rsp_cnt - o_pop + i_rsp_credit;
      o_rsp_valid <= o_pop;
    end
  end

  always_ff @(posedge i_clk) begin
    if (o_pop) begin
      o_rsp <= alu_rsp;
    end
  end

endmodule

`default_nettype wire

// File: csr_regs.sv
/* machine csr file
   mscratch, mtvec, mepc and free-running mcycle */
`timescale 1ns/1ns
`default_nettype none

module csr_regs (
  input  wire                            i_clk,
  input  wire                            i_rst_n,
  input  wire [11:0]                     i_addr,
  input  wire                            i_ren,
  input  wire                            i_wen,
  input  wire [rv_exe_pkg::XLEN-1:0]     i_wdata,
  output logic [rv_exe_pkg::XLEN-1:0]    o_rdata
);

  logic [rv_exe_pkg::XLEN-1:0] mscratch;
  logic [rv_exe_pkg::XLEN-1:0] mtvec;
  logic [rv_exe_pkg::XLEN-1:0] mepc;
  logic [rv_exe_pkg::XLEN-1:0] mcycle;

  always_comb begin
    o_rdata = '0;
    if (i_ren) begin
      case (i_addr)
        rv_exe_pkg::CSR_MSCRATCH: o_rdata = mscratch;
        rv_exe_pkg::CSR_MTVEC:    o_rdata = mtvec;
        rv_exe_pkg::CSR_MEPC:     o_rdata = mepc;
        rv_exe_pkg::CSR_MCYCLE:   o_rdata = mcycle;
        default:                  o_rdata = '0;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      mscratch <= '0;
      mtvec    <= '0;
      mepc     <= '0;
      mcycle   <= '0;
    end else begin
      if (i_wen && i_addr == rv_exe_pkg::CSR_MSCRATCH) mscratch <= i_wdata;
      if (i_wen && i_addr == rv_exe_pkg::CSR_MTVEC)    mtvec    <= i_wdata;
      if (i_wen && i_addr == rv_exe_pkg::CSR_MEPC)     mepc     <= i_wdata;
      // a write wins over the count for that cycle
      if (i_wen && i_addr == rv_exe_pkg::CSR_MCYCLE) begin
        mcycle <= i_wdata;
      end else begin
        mcycle <= mcycle + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: exe_alu.sv
/* execute unit, combinational
   alu results, branch and jump decisions, csr read-modify-write data */
`timescale 1ns/1ns
`default_nettype none

module exe_alu (
  input  wire                            i_ena,
  input  rv_exe_pkg::exe_req_t           i_req,
  input  wire [rv_exe_pkg::XLEN-1:0]     i_csr_rdata,
  output logic [11:0]                    o_csr_addr,
  output logic                           o_csr_ren,
  output logic                           o_csr_wen,
  output logic [rv_exe_pkg::XLEN-1:0]    o_csr_wdata,
  output rv_exe_pkg::exe_rsp_t           o_rsp
);

  logic [rv_exe_pkg::XLEN-1:0] op1;
  logic [rv_exe_pkg::XLEN-1:0] op2;
  logic [rv_exe_pkg::XLEN-1:0] op3;
  logic [rv_exe_pkg::XLEN-1:0] sum;
  logic [rv_exe_pkg::XLEN-1:0] diff;
  logic [5:0]                  shamt;
  logic [4:0]                  shamt_w;
  logic [31:0]                 sll_w;
  logic [31:0]                 srl_w;
  logic [31:0]                 sra_w;
  logic                        is_csr;

  function automatic logic [rv_exe_pkg::XLEN-1:0] sext32(input logic [31:0] val);
    return {{32{val[31]}}, val};
  endfunction

  assign op1     = i_req.op1;
  assign op2     = i_req.op2;
  assign op3     = i_req.op3;
  assign sum     = op1 + op2;
  assign diff    = op1 - op2;
  assign shamt   = op2[5:0];
  assign shamt_w = op2[4:0];
  assign sll_w   = op1[31:0] << shamt_w;
  assign srl_w   = op1[31:0] >> shamt_w;
  assign sra_w   = $signed(op1[31:0]) >>> shamt_w;

  assign is_csr = i_req.op inside {rv_exe_pkg::OP_CSRRW, rv_exe_pkg::OP_CSRRS,
                                   rv_exe_pkg::OP_CSRRC, rv_exe_pkg::OP_CSRRWI,
                                   rv_exe_pkg::OP_CSRRSI, rv_exe_pkg::OP_CSRRCI};

  assign o_csr_ren  = i_ena && is_csr;
  assign o_csr_wen  = i_ena && is_csr;
  assign o_csr_addr = (i_ena && is_csr) ? op2[11:0] : 12'd0;

  always_comb begin
    o_rsp = '0;
    if (i_ena) begin
      case (i_req.op)
        rv_exe_pkg::OP_ADD, rv_exe_pkg::OP_ADDI: o_rsp.rd_wdata = sum;
        rv_exe_pkg::OP_SUB:                      o_rsp.rd_wdata = diff;
        rv_exe_pkg::OP_ADDIW:                    o_rsp.rd_wdata = sext32(sum[31:0]);
        rv_exe_pkg::OP_SUBW:                     o_rsp.rd_wdata = sext32(diff[31:0]);
        rv_exe_pkg::OP_AND, rv_exe_pkg::OP_ANDI: o_rsp.rd_wdata = op1 & op2;
        rv_exe_pkg::OP_OR, rv_exe_pkg::OP_ORI:   o_rsp.rd_wdata = op1 | op2;
        rv_exe_pkg::OP_XOR, rv_exe_pkg::OP_XORI: o_rsp.rd_wdata = op1 ^ op2;
        rv_exe_pkg::OP_SLL, rv_exe_pkg::OP_SLLI: o_rsp.rd_wdata = op1 << shamt;
        rv_exe_pkg::OP_SLLW, rv_exe_pkg::OP_SLLIW: o_rsp.rd_wdata = sext32(sll_w);
        rv_exe_pkg::OP_SRL, rv_exe_pkg::OP_SRLI: o_rsp.rd_wdata = op1 >> shamt;
        rv_exe_pkg::OP_SRLW, rv_exe_pkg::OP_SRLIW: o_rsp.rd_wdata = sext32(srl_w);
        rv_exe_pkg::OP_SRA, rv_exe_pkg::OP_SRAI: o_rsp.rd_wdata = $signed(op1) >>> shamt;
        rv_exe_pkg::OP_SRAW, rv_exe_pkg::OP_SRAIW: o_rsp.rd_wdata = sext32(sra_w);
        rv_exe_pkg::OP_SLT, rv_exe_pkg::OP_SLTI:
          o_rsp.rd_wdata = {63'd0, $signed(op1) < $signed(op2)};
        rv_exe_pkg::OP_SLTU, rv_exe_pkg::OP_SLTIU: o_rsp.rd_wdata = {63'd0, op1 < op2};
        rv_exe_pkg::OP_LUI:                      o_rsp.rd_wdata = op1;
        rv_exe_pkg::OP_AUIPC:                    o_rsp.rd_wdata = sum;
        rv_exe_pkg::OP_JAL: begin
          o_rsp.rd_wdata   = sum;
          o_rsp.pc_jmp     = 1'b1;
          o_rsp.pc_jmpaddr = op3;
        end
        rv_exe_pkg::OP_JALR: begin
          o_rsp.rd_wdata   = op3;
          o_rsp.pc_jmp     = 1'b1;
          o_rsp.pc_jmpaddr = {sum[rv_exe_pkg::XLEN-1:1], 1'b0};
        end
        // branches always report the target, pc_jmp says if taken
        rv_exe_pkg::OP_BEQ: begin
          o_rsp.pc_jmp     = (op1 == op2);
          o_rsp.pc_jmpaddr = op3;
        end
        rv_exe_pkg::OP_BNE: begin
          o_rsp.pc_jmp     = (op1 != op2);
          o_rsp.pc_jmpaddr = op3;
        end
        rv_exe_pkg::OP_BLT: begin
          o_rsp.pc_jmp     = ($signed(op1) < $signed(op2));
          o_rsp.pc_jmpaddr = op3;
        end
        rv_exe_pkg::OP_BGE: begin
          o_rsp.pc_jmp     = ($signed(op1) >= $signed(op2));
          o_rsp.pc_jmpaddr = op3;
        end
        rv_exe_pkg::OP_BLTU: begin
          o_rsp.pc_jmp     = (op1 < op2);
          o_rsp.pc_jmpaddr = op3;
        end
        rv_exe_pkg::OP_BGEU: begin
          o_rsp.pc_jmp     = (op1 >= op2);
          o_rsp.pc_jmpaddr = op3;
        end
        rv_exe_pkg::OP_CSRRW, rv_exe_pkg::OP_CSRRS, rv_exe_pkg::OP_CSRRC,
        rv_exe_pkg::OP_CSRRWI, rv_exe_pkg::OP_CSRRSI, rv_exe_pkg::OP_CSRRCI: begin
          o_rsp.rd_wdata = i_csr_rdata;
          // mcycle reads are not reproducible at commit
          o_rsp.skip_cmt = (o_csr_addr == rv_exe_pkg::CSR_MCYCLE);
        end
        default: o_rsp = '0;
      endcase
    end
  end

  always_comb begin
    o_csr_wdata = '0;
    if (i_ena) begin
      case (i_req.op)
        rv_exe_pkg::OP_CSRRW, rv_exe_pkg::OP_CSRRWI: o_csr_wdata = op1;
        rv_exe_pkg::OP_CSRRS, rv_exe_pkg::OP_CSRRSI: o_csr_wdata = i_csr_rdata | op1;
        rv_exe_pkg::OP_CSRRC, rv_exe_pkg::OP_CSRRCI: o_csr_wdata = i_csr_rdata & ~op1;
        default: o_csr_wdata = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: credit_fifo.sv
/* request queue with credit return
   one registered credit pulse goes upstream per popped entry */
`timescale 1ns/1ns
`default_nettype none

module credit_fifo (
  input  wire                  i_clk,
  input  wire                  i_rst_n,
  input  wire                  i_push,
  input  rv_exe_pkg::exe_req_t i_data,
  input  wire                  i_pop,
  output rv_exe_pkg::exe_req_t o_head,
  output logic                 o_nonempty,
  output logic                 o_credit
);

  rv_exe_pkg::exe_req_t                 mem [rv_exe_pkg::REQ_DEPTH];
  logic [rv_exe_pkg::REQ_PTR_W-1:0]     wr_ptr;
  logic [rv_exe_pkg::REQ_PTR_W-1:0]     rd_ptr;
  logic [rv_exe_pkg::REQ_CNT_W-1:0]     count;
  logic                                 do_pop;

  assign o_nonempty = (count != '0);
  assign o_head     = mem[rd_ptr];
  assign do_pop     = i_pop && o_nonempty;

  always_ff @(posedge i_clk) begin
    if (i_push) begin
      mem[wr_ptr] <= i_data;
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      o_credit <= 1'b0;
    end else begin
      if (i_push) begin
        wr_ptr <= (wr_ptr == rv_exe_pkg::REQ_PTR_W'(rv_exe_pkg::REQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == rv_exe_pkg::REQ_PTR_W'(rv_exe_pkg::REQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count    <= count + i_push - do_pop;
      o_credit <= do_pop;
    end
  end

endmodule

`default_nettype wire

// File: rv_exe_pkg.sv
/* rv64i execute stage shared definitions
   operation codes, request and response payloads, csr map, credit depths */
`default_nettype none

package rv_exe_pkg;

  localparam int XLEN = 64;

  // credit depths
  localparam int REQ_DEPTH   = 4;
  localparam int RSP_CREDITS = 2;
  localparam int REQ_PTR_W   = $clog2(REQ_DEPTH);
  localparam int REQ_CNT_W   = $clog2(REQ_DEPTH + 1);
  localparam int RSP_CNT_W   = $clog2(RSP_CREDITS + 1);

  // csr map
  localparam logic [11:0] CSR_MSCRATCH = 12'h340;
  localparam logic [11:0] CSR_MTVEC    = 12'h305;
  localparam logic [11:0] CSR_MEPC     = 12'h341;
  localparam logic [11:0] CSR_MCYCLE   = 12'hB00;

  // code 0 is left unused, it executes as an unknown op
  typedef enum logic [7:0] {
    OP_NONE = 8'h00,
    OP_ADD, OP_ADDI, OP_SUB, OP_ADDIW, OP_SUBW,
    OP_AND, OP_ANDI, OP_OR, OP_ORI, OP_XOR, OP_XORI,
    OP_SLL, OP_SLLI, OP_SLLW, OP_SLLIW,
    OP_SRL, OP_SRLI, OP_SRLW, OP_SRLIW,
    OP_SRA, OP_SRAI, OP_SRAW, OP_SRAIW,
    OP_SLT, OP_SLTI, OP_SLTU, OP_SLTIU,
    OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
    OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
    OP_CSRRW, OP_CSRRS, OP_CSRRC,
    OP_CSRRWI, OP_CSRRSI, OP_CSRRCI
  } exe_op_e;

  typedef struct packed {
    exe_op_e          op;
    logic [XLEN-1:0]  op1;
    // csr ops carry the address in op2[11:0]
    logic [XLEN-1:0]  op2;
    // branch target, or link value for jalr
    logic [XLEN-1:0]  op3;
  } exe_req_t;

  typedef struct packed {
    logic [XLEN-1:0]  rd_wdata;
    logic             pc_jmp;
    logic [XLEN-1:0]  pc_jmpaddr;
    logic             skip_cmt;
  } exe_rsp_t;

endpackage

`default_nettype wire
